// ==== Bender.yml ====
package:
  name: pipeSpine

sources:
  - logic/corePkg.sv
  - logic/pipePkg.sv
  - logic/fetchStage.sv
  - logic/stageReg.sv
  - logic/memWaitTimer.sv
  - logic/hazardFsm.sv
  - logic/pipeSpine.sv
  - target: test
    files:
      - verif/pipeSpine_props.sv
      - verif/pipeSpine_tb.sv

// ==== logic/corePkg.sv ====
package corePkg;

	// ******************************
	// widths and basic types
	// ******************************

	localparam int xlen = 32;        // data and address width
	localparam int regIdxWidth = 5;
	localparam int opcodeWidth = 6;

	typedef logic [xlen-1:0] addrT;
	typedef logic [xlen-1:0] instrT;
	typedef logic [regIdxWidth-1:0] regIdxT;
	typedef logic [opcodeWidth-1:0] opcodeT;

	// ******************************
	// instruction field positions
	// ******************************

	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 26;
	localparam int rsMsb = 25;
	localparam int rsLsb = 21;
	localparam int rtMsb = 20;
	localparam int rtLsb = 16;
	localparam int rdMsb = 15;
	localparam int rdLsb = 11;

	// ******************************
	// opcodes and PC constants
	// ******************************

	localparam opcodeT opLoad = 6'h23;   // lw
	localparam opcodeT opStore = 6'h2B;  // sw

	localparam addrT resetVector = 32'hBFC0_0000;  // boot rom
	localparam addrT instrBytes = 32'd4;           // one word per instr

endpackage

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
	input  logic clk,
	input  logic reset,
	input  logic pcEnable,
	input  logic ifIdEnable,
	input  logic ifIdFlush,
	input  logic redirect,
	input  corePkg::addrT redirectPc,
	input  corePkg::instrT fetchInstr,
	output corePkg::addrT fetchPc,
	output logic idValid,
	output corePkg::addrT idPc,
	output corePkg::opcodeT idOpcode,
	output corePkg::regIdxT idRs,
	output corePkg::regIdxT idRt,
	output corePkg::regIdxT idDest
);

	corePkg::opcodeT fetchOpcode;
	corePkg::regIdxT fetchRs;
	corePkg::regIdxT fetchRt;
	corePkg::regIdxT fetchRd;

	assign fetchOpcode = fetchInstr[corePkg::opcodeMsb:corePkg::opcodeLsb];
	assign fetchRs = fetchInstr[corePkg::rsMsb:corePkg::rsLsb];
	assign fetchRt = fetchInstr[corePkg::rtMsb:corePkg::rtLsb];
	assign fetchRd = fetchInstr[corePkg::rdMsb:corePkg::rdLsb];

	// ******************************
	// PF stage
	// ******************************

	always_ff @(posedge clk) begin
		if (reset) begin
			fetchPc <= corePkg::resetVector;
		end else if (pcEnable) begin
			fetchPc <= redirect ? redirectPc : fetchPc + corePkg::instrBytes;
		end
	end

	// ******************************
	// IF/ID latch
	// ******************************

	always_ff @(posedge clk) begin
		if (reset || ifIdFlush) begin  // flush beats hold
			idValid <= 1'b0;
			idPc <= '0;
			idOpcode <= '0;
			idRs <= '0;
			idRt <= '0;
			idDest <= '0;
		end else if (ifIdEnable) begin
			idValid <= 1'b1;
			idPc <= fetchPc;
			idOpcode <= fetchOpcode;
			idRs <= fetchRs;
			idRt <= fetchRt;
			idDest <= (fetchOpcode == corePkg::opLoad) ? fetchRt : fetchRd;  // load writes rt
		end
	end

endmodule

// ==== logic/hazardFsm.sv ====
`timescale 1ns/1ps

module hazardFsm (
	input  logic clk,
	input  logic reset,
	input  logic redirect,
	input  logic idValid,
	input  corePkg::regIdxT idRs,
	input  corePkg::regIdxT idRt,
	input  logic exValid,
	input  corePkg::opcodeT exOpcode,
	input  corePkg::regIdxT exDest,
	input  logic memEntryLoad,
	input  logic timerDone,
	output logic timerStart,
	output logic pcEnable,
	output logic ifIdEnable,
	output logic ifIdFlush,
	output logic idExEnable,
	output logic idExFlush,
	output logic exMemEnable,
	output logic memWbEnable,
	output logic memWbFlush,
	output logic stalled
);

	pipePkg::ctrlStateT state;
	pipePkg::ctrlStateT nextState;
	logic loadUse;

	// load in EX whose result the decoding instr reads
	assign loadUse = exValid && (exOpcode == corePkg::opLoad) && idValid &&
		((exDest == idRs) || (exDest == idRt));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pipePkg::run;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			pipePkg::run: if (memEntryLoad) nextState = pipePkg::memWait;
			pipePkg::memWait: if (timerDone) nextState = pipePkg::run;
			default: nextState = pipePkg::run;
		endcase
	end

	// ******************************
	// stage steering
	// ******************************

	always_comb begin
		timerStart = 1'b0;
		ifIdFlush = 1'b0;
		if (state == pipePkg::run) begin
			pcEnable = !loadUse;
			ifIdEnable = !loadUse;
			idExEnable = 1'b1;
			idExFlush = loadUse;     // bubble behind the load
			exMemEnable = 1'b1;
			memWbEnable = 1'b1;
			memWbFlush = 1'b0;
			timerStart = memEntryLoad;
		end else begin
			pcEnable = 1'b0;         // freeze up to EX/MEM
			ifIdEnable = 1'b0;
			idExEnable = 1'b0;
			idExFlush = 1'b0;
			exMemEnable = 1'b0;
			memWbEnable = 1'b0;
			memWbFlush = 1'b1;
		end

		// redirect squashes the two youngest stages in any state
		if (redirect) begin
			pcEnable = 1'b1;
			ifIdFlush = 1'b1;
			idExFlush = 1'b1;
		end

		stalled = !pcEnable;
	end

endmodule

// ==== logic/memWaitTimer.sv ====
`timescale 1ns/1ps

module memWaitTimer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic busy,
	output logic done
);

	logic [pipePkg::timerWidth-1:0] count;
	logic [pipePkg::timerWidth-1:0] countNext;

	assign countNext = count - 1'b1;
	assign busy = (count != '0);
	assign done = busy && (countNext == '0);  // last wait cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (start) begin
			count <= pipePkg::memWaitCycles;
		end else if (busy) begin
			count <= countNext;
		end
	end

endmodule

// ==== logic/pipePkg.sv ====
package pipePkg;

	// ******************************
	// stage payloads
	// ******************************

	// decode to execute
	typedef struct packed {
		corePkg::addrT pc;
		corePkg::opcodeT opcode;
		corePkg::regIdxT rs;
		corePkg::regIdxT rt;
		corePkg::regIdxT dest;  // rt for loads, rd otherwise
	} idExPayloadT;

	// execute to memory
	typedef struct packed {
		corePkg::addrT pc;
		corePkg::opcodeT opcode;
		corePkg::regIdxT dest;
	} exMemPayloadT;

	// memory to writeback
	typedef struct packed {
		corePkg::addrT pc;
		corePkg::regIdxT dest;
	} memWbPayloadT;

	// ******************************
	// control FSM
	// ******************************

	typedef enum logic [0:0] {
		run = 1'b0,      // pipe flows
		memWait = 1'b1   // load holds the memory stage
	} ctrlStateT;

	// extra cycles a load spends in the memory stage
	localparam int timerWidth = 2;
	localparam logic [timerWidth-1:0] memWaitCycles = 2'd2;

endpackage

// ==== logic/pipeSpine.sv ====
`timescale 1ns/1ps

module pipeSpine (
	input  logic clk,
	input  logic reset,
	output corePkg::addrT fetchPc,
	input  corePkg::instrT fetchInstr,
	input  logic redirect,
	input  corePkg::addrT redirectPc,
	output logic retireValid,
	output corePkg::addrT retirePc,
	output corePkg::regIdxT retireDest,
	output logic stalled
);

	// ******************************
	// wires
	// ******************************

	logic pcEnable;
	logic ifIdEnable;
	logic ifIdFlush;
	logic idExEnable;
	logic idExFlush;
	logic exMemEnable;
	logic memWbEnable;
	logic memWbFlush;
	logic timerStart;
	logic timerDone;
	logic memEntryLoad;

	logic idValid;
	corePkg::addrT idPc;
	corePkg::opcodeT idOpcode;
	corePkg::regIdxT idRs;
	corePkg::regIdxT idRt;
	corePkg::regIdxT idDest;

	logic exValid;
	logic memValid;
	pipePkg::idExPayloadT idExIn;
	pipePkg::idExPayloadT idExOut;
	pipePkg::exMemPayloadT exMemIn;
	pipePkg::exMemPayloadT exMemOut;
	pipePkg::memWbPayloadT memWbIn;
	pipePkg::memWbPayloadT memWbOut;

	assign idExIn = '{pc: idPc, opcode: idOpcode, rs: idRs, rt: idRt, dest: idDest};
	assign exMemIn = '{pc: idExOut.pc, opcode: idExOut.opcode, dest: idExOut.dest};
	assign memWbIn = '{pc: exMemOut.pc, dest: exMemOut.dest};

	// load moving into the memory stage this edge
	assign memEntryLoad = exValid && (idExOut.opcode == corePkg::opLoad) && exMemEnable;

	assign retirePc = memWbOut.pc;
	assign retireDest = memWbOut.dest;

	// ******************************
	// instances
	// ******************************

	fetchStage fetch (
		.clk(clk), .reset(reset),
		.pcEnable(pcEnable), .ifIdEnable(ifIdEnable), .ifIdFlush(ifIdFlush),
		.redirect(redirect), .redirectPc(redirectPc), .fetchInstr(fetchInstr),
		.fetchPc(fetchPc), .idValid(idValid), .idPc(idPc), .idOpcode(idOpcode),
		.idRs(idRs), .idRt(idRt), .idDest(idDest)
	);

	hazardFsm ctrl (
		.clk(clk), .reset(reset), .redirect(redirect),
		.idValid(idValid), .idRs(idRs), .idRt(idRt),
		.exValid(exValid), .exOpcode(idExOut.opcode), .exDest(idExOut.dest),
		.memEntryLoad(memEntryLoad), .timerDone(timerDone), .timerStart(timerStart),
		.pcEnable(pcEnable), .ifIdEnable(ifIdEnable), .ifIdFlush(ifIdFlush),
		.idExEnable(idExEnable), .idExFlush(idExFlush), .exMemEnable(exMemEnable),
		.memWbEnable(memWbEnable), .memWbFlush(memWbFlush), .stalled(stalled)
	);

	memWaitTimer waitTimer (
		.clk(clk), .reset(reset), .start(timerStart),
		.busy(), .done(timerDone)
	);

	stageReg #(.payloadT(pipePkg::idExPayloadT)) idEx (
		.clk(clk), .reset(reset), .enable(idExEnable), .flush(idExFlush),
		.inValid(idValid), .inPayload(idExIn), .outValid(exValid), .outPayload(idExOut)
	);

	stageReg #(.payloadT(pipePkg::exMemPayloadT)) exMem (
		.clk(clk), .reset(reset), .enable(exMemEnable), .flush(1'b0),  // never squashed
		.inValid(exValid), .inPayload(exMemIn), .outValid(memValid), .outPayload(exMemOut)
	);

	stageReg #(.payloadT(pipePkg::memWbPayloadT)) memWb (
		.clk(clk), .reset(reset), .enable(memWbEnable), .flush(memWbFlush),
		.inValid(memValid), .inPayload(memWbIn), .outValid(retireValid), .outPayload(memWbOut)
	);

endmodule

// ==== logic/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic flush,
	input  logic inValid,
	input  payloadT inPayload,
	output logic outValid,
	output payloadT outPayload
);

	// flush wins, then enable, else hold
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			outValid <= 1'b0;
			outPayload <= '0;  // bubble
		end else if (enable) begin
			outValid <= inValid;
			outPayload <= inPayload;
		end
	end

endmodule

// ==== pipeSpine.f ====
logic/corePkg.sv
logic/pipePkg.sv
logic/fetchStage.sv
logic/stageReg.sv
logic/memWaitTimer.sv
logic/hazardFsm.sv
logic/pipeSpine.sv
verif/pipeSpine_props.sv
verif/pipeSpine_tb.sv

// ==== verif/pipeSpine_props.sv ====
`timescale 1ns/1ps

module pipeSpine_props (
	input  logic clk,
	input  logic reset,
	input  logic redirect,
	input  logic pcEnable,
	input  logic ifIdFlush,
	input  logic timerStart,
	input  logic memWbEnable,
	input  pipePkg::ctrlStateT state
);

	// ******************************
	// steering rules of the FSM
	// ******************************

	redirectTakesEffect: assert property (@(posedge clk) disable iff (reset)
		redirect |-> (pcEnable || ifIdFlush))
		else $error("redirect with pcEnable and ifIdFlush both low");

	timerStartInRun: assert property (@(posedge clk) disable iff (reset)
		timerStart |-> (state == pipePkg::run))
		else $error("timerStart raised outside state run");

	memWbFrozenInWait: assert property (@(posedge clk) disable iff (reset)
		(state == pipePkg::memWait) |-> !memWbEnable)
		else $error("memWbEnable high in state memWait");

	// wait state never outlives the timer
	memWaitEnds: assert property (@(posedge clk) disable iff (reset)
		(state == pipePkg::memWait) |-> ##[1:pipePkg::memWaitCycles] (state == pipePkg::run))
		else $error("state memWait lasted longer than the memory wait");

endmodule

// ==== verif/pipeSpine_tb.sv ====
`timescale 1ns/1ps

module pipeSpine_tb;

	localparam int clkPeriod = 10;
	localparam int resetCycles = 16;
	localparam int numInstr = 2000;
	localparam int waitCycles = pipePkg::memWaitCycles;
	localparam int runCycles = resetCycles + numInstr * (waitCycles + 2) + 200;
	localparam int seed = 52313;

	logic clk;
	logic reset;
	corePkg::addrT fetchPc;
	corePkg::instrT fetchInstr;
	logic redirect;
	corePkg::addrT redirectPc;
	logic retireValid;
	corePkg::addrT retirePc;
	corePkg::regIdxT retireDest;
	logic stalled;

	logic [31:0] salt;          // mixes the seed into the program
	corePkg::addrT targets[$];  // redirect targets still to retire
	corePkg::addrT lastPc;
	corePkg::instrT lastInstr;
	int cycle;
	int retired;
	int lastRetireCycle;
	int nextRedirect;
	int stallCount;
	int stallMarkLast;
	int stallMarkOlder;
	int errorCount;

	pipeSpine dut_i (
		.clk(clk), .reset(reset),
		.fetchPc(fetchPc), .fetchInstr(fetchInstr),
		.redirect(redirect), .redirectPc(redirectPc),
		.retireValid(retireValid), .retirePc(retirePc), .retireDest(retireDest),
		.stalled(stalled)
	);

	bind hazardFsm pipeSpine_props props (
		.clk(clk), .reset(reset), .redirect(redirect), .pcEnable(pcEnable),
		.ifIdFlush(ifIdFlush), .timerStart(timerStart), .memWbEnable(memWbEnable),
		.state(state)
	);

	always #5 clk = ~clk;

	// ******************************
	// instruction memory model
	// ******************************

	function automatic corePkg::instrT instrAt(corePkg::addrT pc);
		logic [31:0] h;
		corePkg::opcodeT op;
		h = (pc ^ salt) * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		h = h * 32'h85EB_CA6B;
		h = h ^ (h >> 13);
		case (h[1:0])
			2'd0: op = corePkg::opLoad;
			2'd1: op = corePkg::opStore;
			default: op = 6'h00;  // alu, R-type
		endcase
		// eight registers only, so load-use pairs are common
		return {op, 2'b00, h[4:2], 2'b00, h[7:5], 2'b00, h[10:8], 11'h000};
	endfunction

	function automatic logic isLoad(corePkg::instrT instr);
		return instr[corePkg::opcodeMsb:corePkg::opcodeLsb] == corePkg::opLoad;
	endfunction

	function automatic corePkg::regIdxT destOf(corePkg::instrT instr);
		if (isLoad(instr)) begin
			return instr[corePkg::rtMsb:corePkg::rtLsb];
		end
		return instr[corePkg::rdMsb:corePkg::rdLsb];
	endfunction

	function automatic logic readsReg(corePkg::instrT instr, corePkg::regIdxT r);
		return (instr[corePkg::rsMsb:corePkg::rsLsb] == r) ||
			(instr[corePkg::rtMsb:corePkg::rtLsb] == r);
	endfunction

	always @(negedge clk) begin
		fetchInstr = instrAt(fetchPc);  // answers in the same cycle
	end

	// ******************************
	// failure reporting
	// ******************************

	task automatic failRun();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, expected, actual);
		errorCount++;
		failRun();
	endtask

	task automatic reportProblem(string what);
		$display("[ERROR] %0t ns: %s", $time, what);
		errorCount++;
		failRun();
	endtask

	// ******************************
	// retire checker
	// ******************************

	task automatic checkCycle();
		corePkg::instrT instr;
		corePkg::addrT seqPc;
		int gap;
		logic isTarget;
		instr = instrAt(retirePc);
		seqPc = lastPc + corePkg::instrBytes;
		gap = cycle - lastRetireCycle;
		isTarget = (targets.size() > 0) && (retirePc == targets[0]);
		if (retireValid) begin
			assert (retireDest == destOf(instr))
				else reportMismatch("retireDest", destOf(instr), retireDest);
			if (retired == 0) begin
				assert (retirePc == corePkg::resetVector)
					else reportMismatch("retirePc", corePkg::resetVector, retirePc);
				assert (cycle == 4 + (isLoad(instr) ? waitCycles : 0))
					else reportProblem($sformatf("first instruction retired %0d cycles after reset",
						cycle));
			end else begin
				if (isTarget) begin
					void'(targets.pop_front());
				end else begin
					assert (retirePc == seqPc) else reportMismatch("retirePc", seqPc, retirePc);
					if (!isLoad(instr)) begin
						if (isLoad(lastInstr) && readsReg(instr, destOf(lastInstr))) begin
							assert (gap >= 2)
								else reportProblem("load-use pair retired without a bubble");
							assert (stallCount > stallMarkOlder)
								else reportProblem("no stalled cycle around a load-use pair");
						end else begin
							assert (gap == 1)
								else reportProblem($sformatf("straight-line retire came %0d cycles late",
									gap));
						end
					end
				end
				if (isLoad(instr)) begin
					assert (gap >= waitCycles + 1)
						else reportProblem($sformatf("load retired only %0d cycles after its predecessor",
							gap));
				end
			end
			stallMarkOlder = stallMarkLast;
			stallMarkLast = stallCount;
			lastPc = retirePc;
			lastInstr = instr;
			lastRetireCycle = cycle;
			retired++;
		end
		if (stalled) begin
			stallCount++;
		end
	endtask

	task automatic driveRedirect();
		redirect = 1'b0;  // one-cycle strobe
		if (cycle >= nextRedirect && retired < numInstr - 50) begin
			redirect = 1'b1;
			redirectPc = $urandom() & 32'hFFFF_FFFC;
			targets.push_back(redirectPc);
			nextRedirect = cycle + 12 + ($urandom() % 24);
		end
	endtask

	// ******************************
	// main sequence and watchdog
	// ******************************

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		redirect = 1'b0;
		redirectPc = '0;
		fetchInstr = '0;
		cycle = 0;
		retired = 0;
		lastRetireCycle = 0;
		nextRedirect = 40;
		stallCount = 0;
		stallMarkLast = 0;
		stallMarkOlder = 0;
		errorCount = 0;
		lastPc = '0;
		lastInstr = '0;
		salt = $urandom(seed);
		repeat (resetCycles) @(negedge clk);
		assert (fetchPc == corePkg::resetVector)
			else reportMismatch("fetchPc", corePkg::resetVector, fetchPc);
		assert (retireValid == 1'b0) else reportMismatch("retireValid", 0, retireValid);
		assert (stalled == 1'b0) else reportMismatch("stalled", 0, stalled);
		reset = 1'b0;
		while (retired < numInstr) begin
			@(negedge clk);
			cycle++;
			checkCycle();
			driveRedirect();
		end
		assert (targets.size() == 0) else reportProblem("a redirect target never retired");
		if (errorCount == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			failRun();
		end
	end

	initial begin
		#(runCycles * clkPeriod);
		$display("[ERROR] %0t ns: watchdog expired with %0d of %0d instructions retired",
			$time, retired, numInstr);
		failRun();
	end

endmodule
